//--- common/mister_frame_cfg.svh
// Download indexes, status bit positions and widths for the frame wrapper; widths must match the host
`ifndef MISTER_FRAME_CFG_SVH
`define MISTER_FRAME_CFG_SVH

// Download indexes sent by the host processor
`define MF_IDX_ROM          8'd0
`define MF_IDX_MOD          8'd1
`define MF_IDX_DIP          8'd254

// Reset values of the configuration words
`define MF_DIPSW_DEFAULT    32'hFFFF_FFFF
`define MF_CORE_MOD_DEFAULT 7'd0

// Number of bytes in the DIP switch word
`define MF_DIP_BYTES        4

// Menu status bits holding the sync offset nibbles
`define MF_HOFS_LSB         24
`define MF_VOFS_LSB         28

// Host transfer widths
`define MF_ADDR_W           27
`define MF_DATA_W           8

// Video counter and offset widths
`define MF_PXL_W            10
`define MF_LINE_W           9
`define MF_OFS_W            4

`endif

//--- common/dwnld_pkg.sv
// Download path types; address and data widths come from the shared config header
`include "mister_frame_cfg.svh"

package dwnld_pkg;

    // Host download index, only the low byte is decoded
    typedef logic [7:0] hps_index_t;

    // Byte address and data of a host write
    typedef logic [`MF_ADDR_W-1:0] ioctl_addr_t;
    typedef logic [`MF_DATA_W-1:0] ioctl_data_t;

    // Configuration words
    typedef logic [31:0] dipsw_t;
    typedef logic [6:0]  core_mod_t;

    // ROM writer states
    typedef enum logic {
        PROG_IDLE,
        PROG_WAIT
    } prog_state_e;

endpackage

//--- common/video_pkg.sv
// Video counter types; sizes fit frames up to 1024 pixels by 512 lines
`include "mister_frame_cfg.svh"

package video_pkg;

    // Pixel position inside a line, zero at the LHBL rise
    typedef logic [`MF_PXL_W-1:0] pxl_cnt_t;

    // Line position inside a frame, zero at the LVBL rise
    typedef logic [`MF_LINE_W-1:0] line_cnt_t;

    // Signed sync shift from the menu, -8 to +7
    typedef logic signed [`MF_OFS_W-1:0] sync_ofs_t;

endpackage

//--- common/hps_xfer_if.sv
// Host download bundle in the clk_rom domain; the host must not raise wr while wait_req is high
`timescale 1ns/1ps

interface hps_xfer_if;
    import dwnld_pkg::*;

    logic        download;
    hps_index_t  index;
    logic        wr;
    ioctl_addr_t addr;
    ioctl_data_t dout;
    // Back-pressure toward the host
    logic        wait_req;

    modport rom_prog_writer (
        input  download,
        input  index,
        input  wr,
        input  addr,
        input  dout,
        output wait_req
    );

    modport cfg_capture (
        input  download,
        input  index,
        input  wr,
        input  addr,
        input  dout
    );

endinterface

//--- dwnld/rom_prog_writer.sv
// ROM-index host writes become one-cycle strobes; only one write is outstanding until prog_rdy
`timescale 1ns/1ps
`include "mister_frame_cfg.svh"

module rom_prog_writer (
    input  logic                   clk_rom,
    input  logic                   rst_n,
    hps_xfer_if.rom_prog_writer    xfer,
    input  logic                   prog_rdy,
    output logic                   ioctl_rom_wr,
    output dwnld_pkg::ioctl_addr_t ioctl_addr,
    output dwnld_pkg::ioctl_data_t ioctl_dout,
    output logic                   downloading
);
    import dwnld_pkg::*;

    prog_state_e state;
    logic        rom_sel;
    logic        rom_write;

    assign rom_sel   = xfer.download && (xfer.index == `MF_IDX_ROM);
    assign rom_write = rom_sel && xfer.wr;

    // Host is held off while the SDRAM side works on the byte
    assign xfer.wait_req = (state == PROG_WAIT);

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            state        <= PROG_IDLE;
            ioctl_rom_wr <= 1'b0;
            downloading  <= 1'b0;
        end else begin
            ioctl_rom_wr <= 1'b0;
            downloading  <= rom_sel;
            case (state)
                PROG_IDLE: begin
                    if (rom_write) begin
                        state        <= PROG_WAIT;
                        ioctl_rom_wr <= 1'b1;
                    end
                end
                PROG_WAIT: begin
                    // Released on the edge after prog_rdy
                    if (prog_rdy) begin
                        state <= PROG_IDLE;
                    end
                end
                default: state <= PROG_IDLE;
            endcase
        end
    end

    // Address and byte follow the accepted write
    always_ff @(posedge clk_rom) begin
        if (rom_write && state == PROG_IDLE) begin
            ioctl_addr <= xfer.addr;
            ioctl_dout <= xfer.dout;
        end
    end

    // Host honours back-pressure
    assert property (@(posedge clk_rom) disable iff (!rst_n)
        xfer.wait_req |-> !(xfer.download && xfer.wr))
        else $error("host write arrived while wait was high");

    // Strobe is a single cycle
    assert property (@(posedge clk_rom) disable iff (!rst_n)
        ioctl_rom_wr |=> !ioctl_rom_wr)
        else $error("ioctl_rom_wr held for two cycles");

endmodule

//--- dwnld/cfg_capture.sv
// DIP bytes at addresses 0 to 3 and the core mode at address 0; other addresses are ignored
`timescale 1ns/1ps
`include "mister_frame_cfg.svh"

module cfg_capture (
    input  logic                 clk_rom,
    input  logic                 rst_n,
    hps_xfer_if.cfg_capture      xfer,
    output dwnld_pkg::dipsw_t    dipsw,
    output dwnld_pkg::core_mod_t core_mod
);
    import dwnld_pkg::*;

    logic dip_write;
    logic mod_write;

    // Byte lane decode
    assign dip_write = xfer.download && xfer.wr
                     && (xfer.index == `MF_IDX_DIP)
                     && (xfer.addr < ioctl_addr_t'(`MF_DIP_BYTES));

    assign mod_write = xfer.download && xfer.wr
                     && (xfer.index == `MF_IDX_MOD)
                     && (xfer.addr == '0);

    always_ff @(posedge clk_rom) begin
        if (!rst_n) begin
            dipsw    <= `MF_DIPSW_DEFAULT;
            core_mod <= `MF_CORE_MOD_DEFAULT;
        end else begin
            if (dip_write) begin
                dipsw[{xfer.addr[1:0], 3'd0} +: 8] <= xfer.dout;
            end
            // Only seven mode bits are kept
            if (mod_write) begin
                core_mod <= xfer.dout[6:0];
            end
        end
    end

    // DIP word moves only right after a DIP write
    assert property (@(posedge clk_rom) disable iff (!rst_n)
        !$stable(dipsw) |-> $past(dip_write))
        else $error("dipsw changed without a DIP write");

endmodule

//--- hdl/sync_resync.sv
// Sync shifted by menu offsets; outputs one pixel behind inputs, valid from the second line and frame
`timescale 1ns/1ps

module sync_resync (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  logic                 pxl_cen,
    input  logic                 hs,
    input  logic                 vs,
    input  logic                 LHBL,
    input  logic                 LVBL,
    input  video_pkg::sync_ofs_t hoffset,
    input  video_pkg::sync_ofs_t voffset,
    output logic                 hs_out,
    output logic                 vs_out
);
    import video_pkg::*;

    sync_ofs_t hofs_meta, hofs_sync;
    sync_ofs_t vofs_meta, vofs_sync;
    pxl_cnt_t  hofs_ext;
    line_cnt_t vofs_ext;

    logic      lhbl_l, hs_l, lvbl_l, vs_l;
    logic      lhbl_rise, line_start, frame_start;
    logic      h_win;
    logic      hs_seen_on, hs_seen_off, vs_seen_on, vs_seen_off;

    pxl_cnt_t  hcnt, cur_h, hs_start, hs_end, act_h_on, act_h_off, hs_out_len;
    line_cnt_t vcnt, cur_v, vs_start, vs_end, act_v_on, act_v_off;

    // Offsets come from the clk_rom side
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hofs_meta <= '0;
            hofs_sync <= '0;
            vofs_meta <= '0;
            vofs_sync <= '0;
        end else begin
            hofs_meta <= hoffset;
            hofs_sync <= hofs_meta;
            vofs_meta <= voffset;
            vofs_sync <= vofs_meta;
        end
    end

    // Sign extended to counter width
    assign hofs_ext = pxl_cnt_t'(hofs_sync);
    assign vofs_ext = line_cnt_t'(vofs_sync);

    assign lhbl_rise   = LHBL && !lhbl_l;
    assign line_start  = pxl_cen && lhbl_rise;
    // LVBL is looked at once per line
    assign frame_start = LVBL && !lvbl_l;

    assign cur_h = lhbl_rise ? '0 : hcnt + 1'b1;
    assign cur_v = frame_start ? '0 : vcnt + 1'b1;
    assign h_win = (cur_h >= act_h_on) && (cur_h < act_h_off);

    // Horizontal measure and regenerate
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            lhbl_l      <= 1'b0;
            hs_l        <= 1'b0;
            hcnt        <= '0;
            hs_seen_on  <= 1'b0;
            hs_seen_off <= 1'b0;
            act_h_on    <= '0;
            act_h_off   <= '0;
            hs_out      <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= LHBL;
            hs_l   <= hs;
            hcnt   <= cur_h;
            if (lhbl_rise) begin
                hs_seen_on  <= 1'b0;
                hs_seen_off <= 1'b0;
                // Empty window until a full line was seen
                if (hs_seen_on && hs_seen_off) begin
                    act_h_on  <= hs_start + hofs_ext;
                    act_h_off <= hs_end + hofs_ext;
                end else begin
                    act_h_on  <= '0;
                    act_h_off <= '0;
                end
            end
            if (hs && !hs_l) begin
                hs_start   <= cur_h;
                hs_seen_on <= 1'b1;
            end
            if (!hs && hs_l) begin
                hs_end      <= cur_h;
                hs_seen_off <= 1'b1;
            end
            hs_out <= h_win;
            if (h_win) begin
                hs_out_len <= hs_out ? hs_out_len + 1'b1 : pxl_cnt_t'(1);
            end
        end
    end

    // Vertical measure and regenerate, switching at LHBL rise
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            lvbl_l      <= 1'b0;
            vs_l        <= 1'b0;
            vcnt        <= '0;
            vs_seen_on  <= 1'b0;
            vs_seen_off <= 1'b0;
            act_v_on    <= '0;
            act_v_off   <= '0;
            vs_out      <= 1'b0;
        end else if (line_start) begin
            lvbl_l <= LVBL;
            vs_l   <= vs;
            vcnt   <= cur_v;
            if (frame_start) begin
                vs_seen_on  <= 1'b0;
                vs_seen_off <= 1'b0;
                if (vs_seen_on && vs_seen_off) begin
                    act_v_on  <= vs_start + vofs_ext;
                    act_v_off <= vs_end + vofs_ext;
                end else begin
                    act_v_on  <= '0;
                    act_v_off <= '0;
                end
            end
            if (vs && !vs_l) begin
                vs_start   <= cur_v;
                vs_seen_on <= 1'b1;
            end
            if (!vs && vs_l) begin
                vs_end      <= cur_v;
                vs_seen_off <= 1'b1;
            end
            vs_out <= (cur_v >= act_v_on) && (cur_v < act_v_off);
        end
    end

    // Shifted pulse keeps the input width
    assert property (@(posedge clk_sys) disable iff (!rst_n)
        $fell(hs_out) |-> hs_out_len == pxl_cnt_t'(hs_end - hs_start))
        else $error("hs_out width differs from measured hs width");

endmodule

//--- hdl/mister_frame.sv
// Download path runs on clk_rom and sync re-timing on clk_sys; rst_n must be synchronous to both
`timescale 1ns/1ps
`include "mister_frame_cfg.svh"

module mister_frame (
    input  logic                   clk_sys,
    input  logic                   clk_rom,
    input  logic                   rst_n,
    // Host download
    input  logic                   hps_download,
    input  dwnld_pkg::hps_index_t  hps_index,
    input  logic                   hps_wr,
    input  dwnld_pkg::ioctl_addr_t hps_addr,
    input  dwnld_pkg::ioctl_data_t hps_dout,
    output logic                   hps_wait,
    input  logic                   prog_rdy,
    // ROM programming
    output logic                   ioctl_rom_wr,
    output dwnld_pkg::ioctl_addr_t ioctl_addr,
    output dwnld_pkg::ioctl_data_t ioctl_dout,
    output logic                   downloading,
    // Configuration
    output dwnld_pkg::dipsw_t      dipsw,
    output dwnld_pkg::core_mod_t   core_mod,
    input  logic [31:0]            status,
    // Video
    input  logic                   pxl_cen,
    input  logic                   hs,
    input  logic                   vs,
    input  logic                   LHBL,
    input  logic                   LVBL,
    output logic                   hs_out,
    output logic                   vs_out
);
    import video_pkg::*;

    sync_ofs_t hoffset;
    sync_ofs_t voffset;

    hps_xfer_if xfer ();

    assign xfer.download = hps_download;
    assign xfer.index    = hps_index;
    assign xfer.wr       = hps_wr;
    assign xfer.addr     = hps_addr;
    assign xfer.dout     = hps_dout;
    assign hps_wait      = xfer.wait_req;

    // Menu offset nibbles
    assign hoffset = status[`MF_HOFS_LSB +: $bits(sync_ofs_t)];
    assign voffset = status[`MF_VOFS_LSB +: $bits(sync_ofs_t)];

    rom_prog_writer u_prog (
        .clk_rom      ( clk_rom      ),
        .rst_n        ( rst_n        ),
        .xfer         ( xfer         ),
        .prog_rdy     ( prog_rdy     ),
        .ioctl_rom_wr ( ioctl_rom_wr ),
        .ioctl_addr   ( ioctl_addr   ),
        .ioctl_dout   ( ioctl_dout   ),
        .downloading  ( downloading  )
    );

    cfg_capture u_cfg (
        .clk_rom  ( clk_rom  ),
        .rst_n    ( rst_n    ),
        .xfer     ( xfer     ),
        .dipsw    ( dipsw    ),
        .core_mod ( core_mod )
    );

    sync_resync u_resync (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .LHBL    ( LHBL    ),
        .LVBL    ( LVBL    ),
        .hoffset ( hoffset ),
        .voffset ( voffset ),
        .hs_out  ( hs_out  ),
        .vs_out  ( vs_out  )
    );

endmodule

//--- verification/mister_frame_tb.sv
// One 8 ns clock feeds clk_sys and clk_rom; video checks use the third frame of each offset pair
`timescale 1ns/1ps
`include "mister_frame_cfg.svh"

module mister_frame_tb;
    import dwnld_pkg::*;
    import video_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int H_TOTAL    = 64;
    localparam int V_TOTAL    = 24;
    localparam int H_ACTIVE   = 48;
    localparam int V_ACTIVE   = 16;
    localparam int HS_ON      = 50;
    localparam int HS_OFF     = 56;
    localparam int VS_ON      = 10;
    localparam int VS_OFF     = 14;
    localparam int DL_N       = 12;
    localparam int VID_N      = 5;
    // Write, longest prog_rdy delay, release and poll
    localparam int DL_WORST   = 12;
    localparam int VID_WORST  = 3 * V_TOTAL * H_TOTAL * 2;
    localparam int TIMEOUT    = (DL_N * DL_WORST + VID_N * VID_WORST + 200) * CLK_PERIOD;

    typedef struct packed {
        hps_index_t  idx;
        ioctl_addr_t addr;
        ioctl_data_t data;
    } dl_entry_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        hps_download;
    hps_index_t  hps_index;
    logic        hps_wr;
    ioctl_addr_t hps_addr;
    ioctl_data_t hps_dout;
    logic        hps_wait;
    logic        prog_rdy;
    logic        ioctl_rom_wr;
    ioctl_addr_t ioctl_addr;
    ioctl_data_t ioctl_dout;
    logic        downloading;
    dipsw_t      dipsw;
    core_mod_t   core_mod;
    logic [31:0] status;
    logic        pxl_cen, hs, vs, LHBL, LVBL;
    logic        hs_out, vs_out;

    // Index, address, byte
    dl_entry_t dl_tab [DL_N] = '{
        '{`MF_IDX_ROM, 27'h000_0000, 8'h3C},
        '{`MF_IDX_ROM, 27'h000_0001, 8'hA5},
        '{`MF_IDX_DIP, 27'h000_0000, 8'h12},
        '{`MF_IDX_DIP, 27'h000_0003, 8'h9E},
        '{`MF_IDX_ROM, 27'h004_0000, 8'h5A},
        '{`MF_IDX_DIP, 27'h000_0004, 8'h00},
        '{`MF_IDX_MOD, 27'h000_0000, 8'hC5},
        '{`MF_IDX_MOD, 27'h000_0001, 8'h33},
        '{`MF_IDX_DIP, 27'h000_0001, 8'h77},
        '{`MF_IDX_ROM, 27'h7FF_FFFF, 8'hFF},
        '{`MF_IDX_DIP, 27'h000_0002, 8'h00},
        '{`MF_IDX_ROM, 27'h123_4567, 8'h81}
    };
    sync_ofs_t hofs_tab [VID_N] = '{4'sd0, 4'sd3, -4'sd8, 4'sd7, -4'sd4};
    sync_ofs_t vofs_tab [VID_N] = '{4'sd0, -4'sd2, 4'sd7, -4'sd8, 4'sd5};

    ioctl_addr_t exp_addr_q [$];
    ioctl_data_t exp_data_q [$];
    dipsw_t      exp_dipsw;
    core_mod_t   exp_core_mod;
    int          errors = 0;
    int          checks = 0;
    int          rom_writes = 0;
    int          rom_strobes = 0;
    integer      seed = 32'h38b70937;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mister_frame UUT (
        .clk_sys (clk), .clk_rom (clk), .rst_n (rst_n),
        .hps_download (hps_download), .hps_index (hps_index), .hps_wr (hps_wr),
        .hps_addr (hps_addr), .hps_dout (hps_dout), .hps_wait (hps_wait),
        .prog_rdy (prog_rdy), .ioctl_rom_wr (ioctl_rom_wr), .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout), .downloading (downloading), .dipsw (dipsw),
        .core_mod (core_mod), .status (status), .pxl_cen (pxl_cen), .hs (hs), .vs (vs),
        .LHBL (LHBL), .LVBL (LVBL), .hs_out (hs_out), .vs_out (vs_out)
    );

    task automatic note_failure(input string msg);
        errors++;
        $display("Check failed at %0t ns: %s", $time, msg);
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_rom(input ioctl_addr_t got_addr, input ioctl_data_t got_data,
                             input ioctl_addr_t exp_addr, input ioctl_data_t exp_data);
        checks++;
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            errors++;
            $display("** Error at %0t ns: ROM write %h/%h, expected %h/%h",
                     $time, got_addr, got_data, exp_addr, exp_data);
        end
    endtask

    task automatic check_dipsw(input dipsw_t got, input dipsw_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: dipsw is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_core_mod(input core_mod_t got, input core_mod_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: core_mod is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_sync_px(input string what, input pxl_cnt_t got, input pxl_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is pixel %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_sync_line(input string what, input line_cnt_t got, input line_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is line %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Poll on falling edges until the host may write again
    task automatic wait_ready();
        int polls;
        polls = 0;
        while (hps_wait && polls < 2 * DL_WORST) begin
            @(negedge clk);
            polls++;
        end
        if (hps_wait)
            note_failure("hps_wait stayed high, the prog_rdy release was not seen");
    endtask

    task automatic apply_download(input dl_entry_t e);
        wait_ready();
        hps_index = e.idx;
        hps_addr  = e.addr;
        hps_dout  = e.data;
        hps_wr    = 1'b1;
        // Reference model of the download path
        if (e.idx == `MF_IDX_ROM) begin
            exp_addr_q.push_back(e.addr);
            exp_data_q.push_back(e.data);
            rom_writes++;
        end
        if (e.idx == `MF_IDX_DIP && e.addr < `MF_DIP_BYTES)
            exp_dipsw[int'(e.addr) * 8 +: 8] = e.data;
        if (e.idx == `MF_IDX_MOD && e.addr == 0)
            exp_core_mod = e.data[6:0];
        @(negedge clk);
        hps_wr = 1'b0;
        check_dipsw(dipsw, exp_dipsw);
        check_core_mod(core_mod, exp_core_mod);
        check_level("downloading", downloading, e.idx == `MF_IDX_ROM);
        check_level("hps_wait after write", hps_wait, e.idx == `MF_IDX_ROM);
    endtask

    // SDRAM side stand-in, answers each strobe after 1 to 6 cycles
    always begin : prog_responder
        int delay;
        @(negedge clk);
        if (rst_n && ioctl_rom_wr) begin
            rom_strobes++;
            if (exp_addr_q.size() == 0)
                note_failure("ROM strobe without a matching ROM-index write");
            else
                check_rom(ioctl_addr, ioctl_dout, exp_addr_q.pop_front(), exp_data_q.pop_front());
            delay = 1 + ({$random(seed)} % 6);
            repeat (delay) begin
                @(negedge clk);
                check_level("hps_wait before prog_rdy", hps_wait, 1'b1);
                check_level("ioctl_rom_wr after strobe", ioctl_rom_wr, 1'b0);
            end
            prog_rdy = 1'b1;
            @(negedge clk);
            prog_rdy = 1'b0;
            check_level("hps_wait after prog_rdy", hps_wait, 1'b0);
        end
    end

    // Three frames per offset pair, pxl_cen on the first cycle of each pixel
    task automatic run_video(input sync_ofs_t hofs, input sync_ofs_t vofs);
        int   h_rise, h_fall, v_rise, v_fall;
        logic h_prev, v_prev;
        status = '0;
        status[`MF_HOFS_LSB +: `MF_OFS_W] = hofs;
        status[`MF_VOFS_LSB +: `MF_OFS_W] = vofs;
        for (int fr = 0; fr < 3; fr++) begin
            v_prev = 1'b0;
            v_rise = -1;
            v_fall = -1;
            for (int ln = 0; ln < V_TOTAL; ln++) begin
                h_prev = 1'b0;
                h_rise = -1;
                h_fall = -1;
                for (int px = 0; px < H_TOTAL; px++) begin
                    LHBL    = (px < H_ACTIVE);
                    hs      = (px >= HS_ON) && (px < HS_OFF);
                    LVBL    = (ln < V_ACTIVE);
                    vs      = (ln >= VS_ON) && (ln < VS_OFF);
                    pxl_cen = 1'b1;
                    @(negedge clk);
                    pxl_cen = 1'b0;
                    if (hs_out && !h_prev)
                        h_rise = px;
                    if (!hs_out && h_prev)
                        h_fall = px;
                    h_prev = hs_out;
                    // vs_out moves only at the LHBL rise
                    if (px == 0) begin
                        if (vs_out && !v_prev)
                            v_rise = ln;
                        if (!vs_out && v_prev)
                            v_fall = ln;
                        v_prev = vs_out;
                    end
                    @(negedge clk);
                end
                if (fr == 2 && (h_rise < 0 || h_fall < 0))
                    note_failure("hs_out gave no complete pulse in a line of the last frame");
                else if (fr == 2) begin
                    check_sync_px("hs_out rise", pxl_cnt_t'(h_rise), pxl_cnt_t'(HS_ON + int'(hofs)));
                    check_sync_px("hs_out width", pxl_cnt_t'(h_fall - h_rise),
                                  pxl_cnt_t'(HS_OFF - HS_ON));
                end
            end
            if (fr == 2 && (v_rise < 0 || v_fall < 0))
                note_failure("vs_out gave no complete pulse in the last frame");
            else if (fr == 2) begin
                check_sync_line("vs_out rise", line_cnt_t'(v_rise), line_cnt_t'(VS_ON + int'(vofs)));
                check_sync_line("vs_out width", line_cnt_t'(v_fall - v_rise),
                                line_cnt_t'(VS_OFF - VS_ON));
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        hps_download = 1'b0;
        hps_index    = '0;
        hps_wr       = 1'b0;
        hps_addr     = '0;
        hps_dout     = '0;
        prog_rdy     = 1'b0;
        status       = '0;
        pxl_cen      = 1'b0;
        hs           = 1'b0;
        vs           = 1'b0;
        LHBL         = 1'b0;
        LVBL         = 1'b0;
        exp_dipsw    = `MF_DIPSW_DEFAULT;
        exp_core_mod = '0;
        repeat (2) @(negedge clk);
        check_level("ioctl_rom_wr in reset", ioctl_rom_wr, 1'b0);
        check_level("hps_wait in reset", hps_wait, 1'b0);
        check_level("downloading in reset", downloading, 1'b0);
        check_level("hs_out in reset", hs_out, 1'b0);
        check_level("vs_out in reset", vs_out, 1'b0);
        check_dipsw(dipsw, exp_dipsw);
        check_core_mod(core_mod, exp_core_mod);
        rst_n        = 1'b1;
        hps_download = 1'b1;
        foreach (dl_tab[i])
            apply_download(dl_tab[i]);
        wait_ready();
        hps_download = 1'b0;
        @(negedge clk);
        check_level("downloading after download end", downloading, 1'b0);
        if (rom_strobes != rom_writes || exp_addr_q.size() != 0)
            note_failure("number of ROM strobes differs from the ROM-index writes");
        foreach (hofs_tab[i])
            run_video(hofs_tab[i], vofs_tab[i]);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Watchdog expired after %0d ns, the run did not complete", TIMEOUT);
        $display("tests failed");
        $finish;
    end

endmodule

//--- mister_frame.f
+incdir+common
common/dwnld_pkg.sv
common/video_pkg.sv
common/hps_xfer_if.sv
dwnld/rom_prog_writer.sv
dwnld/cfg_capture.sv
hdl/sync_resync.sv
hdl/mister_frame.sv
verification/mister_frame_tb.sv
